/* sw_pkg.sv */
package sw_pkg;

  ////////////////////////////////////////////////////////////
  // Timing. Sized for simulation, raise for a board build.
  ////////////////////////////////////////////////////////////

  localparam int DEBOUNCE_CYCLES   = 8;
  localparam int DEB_W             = 4;
  localparam int CLK_PER_HUNDREDTH = 16;
  localparam int PRESC_W           = 5;
  localparam int SCAN_CYCLES       = 4;
  localparam int SCAN_W            = 2;
  localparam int NUM_DIGITS        = 4;

  ////////////////////////////////////////////////////////////
  // Types.
  ////////////////////////////////////////////////////////////

  typedef logic [3:0] bcd_t;

  typedef enum logic [2:0] {
    RUN_STATE    = 3'd0,
    CHANGE_TEN   = 3'd1,
    CHANGE_SEC   = 3'd2,
    CHANGE_TENTH = 3'd3,
    CHANGE_HUND  = 3'd4
  } setter_state_e;

  // Segments gfedcba, active high; non-BCD codes blank.
  function automatic logic [6:0] seg_of(input bcd_t d);
    case (d)
      4'd0:    return 7'b0111111;
      4'd1:    return 7'b0000110;
      4'd2:    return 7'b1011011;
      4'd3:    return 7'b1001111;
      4'd4:    return 7'b1100110;
      4'd5:    return 7'b1101101;
      4'd6:    return 7'b1111101;
      4'd7:    return 7'b0000111;
      4'd8:    return 7'b1111111;
      4'd9:    return 7'b1101111;
      default: return 7'b0000000;
    endcase
  endfunction

endpackage

/* button_conditioner.sv */
module button_conditioner (
  input  logic clk_i,
  input  logic rstn_i,
  input  logic btn_start_i,
  input  logic btn_set_i,
  input  logic btn_change_i,
  output logic start_press_o,
  output logic set_press_o,
  output logic change_press_o
);
  import sw_pkg::*;

  logic [2:0] btn_raw;
  logic [2:0] press;

  assign btn_raw = {btn_change_i, btn_set_i, btn_start_i};

  // One channel per button: sync, debounce, rising edge.
  for (genvar ch = 0; ch < 3; ch++)
  begin : g_chan
    logic             sync1_q;
    logic             sync2_q;
    logic             level_q;
    logic             level_d_q;
    logic             press_q;
    logic [DEB_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
      if (!rstn_i)
      begin
        sync1_q   <= 1'b0;
        sync2_q   <= 1'b0;
        level_q   <= 1'b0;
        level_d_q <= 1'b0;
        press_q   <= 1'b0;
        cnt_q     <= '0;
      end
      else
      begin
        sync1_q   <= btn_raw[ch];
        sync2_q   <= sync1_q;
        level_d_q <= level_q;
        press_q   <= level_q & ~level_d_q;
        // Any return to the accepted level restarts the count.
        if (sync2_q == level_q)
          cnt_q <= '0;
        else if (cnt_q == DEB_W'(DEBOUNCE_CYCLES - 1))
        begin
          level_q <= sync2_q;
          cnt_q   <= '0;
        end
        else
          cnt_q <= cnt_q + 1'b1;
      end
    end

    assign press[ch] = press_q;
  end

  assign start_press_o  = press[0];
  assign set_press_o    = press[1];
  assign change_press_o = press[2];

endmodule

/* time_counter.sv */
module time_counter (
  input  logic        clk_i,
  input  logic        rstn_i,
  input  logic        start_press_i,
  input  logic        edit_i,
  input  logic        load_i,
  input  sw_pkg::bcd_t load_hund_i,
  input  sw_pkg::bcd_t load_tenth_i,
  input  sw_pkg::bcd_t load_sec_i,
  input  sw_pkg::bcd_t load_ten_i,
  output logic        run_o,
  output sw_pkg::bcd_t hund_o,
  output sw_pkg::bcd_t tenth_o,
  output sw_pkg::bcd_t sec_o,
  output sw_pkg::bcd_t ten_o
);
  import sw_pkg::*;

  logic               run_q;
  logic [PRESC_W-1:0] presc_q;
  logic               tick_q;
  bcd_t               hund_q;
  bcd_t               tenth_q;
  bcd_t               sec_q;
  bcd_t               ten_q;

  ////////////////////////////////////////////////////////////
  // Run flag and hundredth prescaler.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      run_q   <= 1'b0;
      presc_q <= '0;
      tick_q  <= 1'b0;
    end
    else
    begin
      // Start is ignored while editing.
      if (start_press_i && !edit_i)
        run_q <= ~run_q;
      tick_q <= 1'b0;
      if (!run_q)
        presc_q <= '0;
      else if (presc_q == PRESC_W'(CLK_PER_HUNDREDTH - 1))
      begin
        presc_q <= '0;
        tick_q  <= 1'b1;
      end
      else
        presc_q <= presc_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // BCD carry chain.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      hund_q  <= '0;
      tenth_q <= '0;
      sec_q   <= '0;
      ten_q   <= '0;
    end
    else if (load_i)
    begin
      hund_q  <= load_hund_i;
      tenth_q <= load_tenth_i;
      sec_q   <= load_sec_i;
      ten_q   <= load_ten_i;
    end
    else if (tick_q)
    begin
      if (hund_q != 4'd9)
        hund_q <= hund_q + 4'd1;
      else
      begin
        hund_q <= '0;
        if (tenth_q != 4'd9)
          tenth_q <= tenth_q + 4'd1;
        else
        begin
          tenth_q <= '0;
          if (sec_q != 4'd9)
            sec_q <= sec_q + 4'd1;
          else
          begin
            sec_q <= '0;
            // 99.99 rolls to 00.00.
            ten_q <= (ten_q == 4'd9) ? 4'd0 : ten_q + 4'd1;
          end
        end
      end
    end
  end

  assign run_o   = run_q;
  assign hund_o  = hund_q;
  assign tenth_o = tenth_q;
  assign sec_o   = sec_q;
  assign ten_o   = ten_q;

endmodule

/* stopwatch_setter.sv */
module stopwatch_setter (
  input  logic         clk_i,
  input  logic         rstn_i,
  input  logic         run_i,
  input  logic         set_press_i,
  input  logic         change_press_i,
  input  sw_pkg::bcd_t hund_i,
  input  sw_pkg::bcd_t tenth_i,
  input  sw_pkg::bcd_t sec_i,
  input  sw_pkg::bcd_t ten_i,
  output logic         edit_o,
  output logic         load_o,
  output sw_pkg::bcd_t edit_hund_o,
  output sw_pkg::bcd_t edit_tenth_o,
  output sw_pkg::bcd_t edit_sec_o,
  output sw_pkg::bcd_t edit_ten_o
);
  import sw_pkg::*;

  setter_state_e state_q;
  setter_state_e state_d;
  logic          load_q;
  bcd_t          hund_q;
  bcd_t          tenth_q;
  bcd_t          sec_q;
  bcd_t          ten_q;

  function automatic bcd_t step(input bcd_t d);
    return (d == 4'd9) ? 4'd0 : d + 4'd1;
  endfunction

  // Tens first, then down to hundredths.
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      RUN_STATE:    if (set_press_i && !run_i) state_d = CHANGE_TEN;
      CHANGE_TEN:   if (set_press_i) state_d = CHANGE_SEC;
      CHANGE_SEC:   if (set_press_i) state_d = CHANGE_TENTH;
      CHANGE_TENTH: if (set_press_i) state_d = CHANGE_HUND;
      CHANGE_HUND:  if (set_press_i) state_d = RUN_STATE;
      default:      state_d = RUN_STATE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      state_q <= RUN_STATE;
      load_q  <= 1'b0;
      hund_q  <= '0;
      tenth_q <= '0;
      sec_q   <= '0;
      ten_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      load_q  <= (state_q == CHANGE_HUND) && set_press_i;
      case (state_q)
        RUN_STATE:
          // Snapshot so the edit starts from the shown time.
          if (set_press_i && !run_i)
          begin
            hund_q  <= hund_i;
            tenth_q <= tenth_i;
            sec_q   <= sec_i;
            ten_q   <= ten_i;
          end
        CHANGE_TEN:   if (change_press_i && !set_press_i) ten_q   <= step(ten_q);
        CHANGE_SEC:   if (change_press_i && !set_press_i) sec_q   <= step(sec_q);
        CHANGE_TENTH: if (change_press_i && !set_press_i) tenth_q <= step(tenth_q);
        CHANGE_HUND:  if (change_press_i && !set_press_i) hund_q  <= step(hund_q);
        default:      ;
      endcase
    end
  end

  assign edit_o       = (state_q != RUN_STATE);
  assign load_o       = load_q;
  assign edit_hund_o  = hund_q;
  assign edit_tenth_o = tenth_q;
  assign edit_sec_o   = sec_q;
  assign edit_ten_o   = ten_q;

endmodule

/* seg_scan.sv */
module seg_scan (
  input  logic                          clk_i,
  input  logic                          rstn_i,
  input  logic                          edit_i,
  input  sw_pkg::bcd_t                  hund_i,
  input  sw_pkg::bcd_t                  tenth_i,
  input  sw_pkg::bcd_t                  sec_i,
  input  sw_pkg::bcd_t                  ten_i,
  input  sw_pkg::bcd_t                  edit_hund_i,
  input  sw_pkg::bcd_t                  edit_tenth_i,
  input  sw_pkg::bcd_t                  edit_sec_i,
  input  sw_pkg::bcd_t                  edit_ten_i,
  output logic [sw_pkg::NUM_DIGITS-1:0] anode_o,
  output logic [6:0]                    seg_o,
  output logic                          dp_o
);
  import sw_pkg::*;

  localparam int IDX_W = $clog2(NUM_DIGITS);

  logic [SCAN_W-1:0] scan_q;
  logic [IDX_W-1:0]  idx_q;
  bcd_t              digit;

  // Index 0 is hund, 3 is ten.
  always_comb
  begin
    case (idx_q)
      2'd0:    digit = edit_i ? edit_hund_i  : hund_i;
      2'd1:    digit = edit_i ? edit_tenth_i : tenth_i;
      2'd2:    digit = edit_i ? edit_sec_i   : sec_i;
      default: digit = edit_i ? edit_ten_i   : ten_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      scan_q  <= '0;
      idx_q   <= '0;
      anode_o <= NUM_DIGITS'(1);
      seg_o   <= seg_of('0);
      dp_o    <= 1'b0;
    end
    else
    begin
      if (scan_q == SCAN_W'(SCAN_CYCLES - 1))
      begin
        scan_q <= '0;
        idx_q  <= idx_q + 1'b1;
      end
      else
        scan_q <= scan_q + 1'b1;
      anode_o <= NUM_DIGITS'(1) << idx_q;
      seg_o   <= seg_of(digit);
      dp_o    <= (idx_q == IDX_W'(2));
    end
  end

endmodule

/* stopwatch_top.sv */
module stopwatch_top (
  input  logic                          clk_i,
  input  logic                          rstn_i,
  input  logic                          btn_start_i,
  input  logic                          btn_set_i,
  input  logic                          btn_change_i,
  output logic [sw_pkg::NUM_DIGITS-1:0] anode_o,
  output logic [6:0]                    seg_o,
  output logic                          dp_o,
  output logic                          run_o,
  output logic                          edit_o
);
  import sw_pkg::*;

  logic start_press;
  logic set_press;
  logic change_press;
  logic load;
  bcd_t hund;
  bcd_t tenth;
  bcd_t sec;
  bcd_t ten;
  bcd_t edit_hund;
  bcd_t edit_tenth;
  bcd_t edit_sec;
  bcd_t edit_ten;

  button_conditioner u_button_conditioner (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .btn_start_i    (btn_start_i),
    .btn_set_i      (btn_set_i),
    .btn_change_i   (btn_change_i),
    .start_press_o  (start_press),
    .set_press_o    (set_press),
    .change_press_o (change_press)
  );

  time_counter u_time_counter (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .start_press_i (start_press),
    .edit_i        (edit_o),
    .load_i        (load),
    .load_hund_i   (edit_hund),
    .load_tenth_i  (edit_tenth),
    .load_sec_i    (edit_sec),
    .load_ten_i    (edit_ten),
    .run_o         (run_o),
    .hund_o        (hund),
    .tenth_o       (tenth),
    .sec_o         (sec),
    .ten_o         (ten)
  );

  stopwatch_setter u_stopwatch_setter (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .run_i          (run_o),
    .set_press_i    (set_press),
    .change_press_i (change_press),
    .hund_i         (hund),
    .tenth_i        (tenth),
    .sec_i          (sec),
    .ten_i          (ten),
    .edit_o         (edit_o),
    .load_o         (load),
    .edit_hund_o    (edit_hund),
    .edit_tenth_o   (edit_tenth),
    .edit_sec_o     (edit_sec),
    .edit_ten_o     (edit_ten)
  );

  seg_scan u_seg_scan (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .edit_i       (edit_o),
    .hund_i       (hund),
    .tenth_i      (tenth),
    .sec_i        (sec),
    .ten_i        (ten),
    .edit_hund_i  (edit_hund),
    .edit_tenth_i (edit_tenth),
    .edit_sec_i   (edit_sec),
    .edit_ten_i   (edit_ten),
    .anode_o      (anode_o),
    .seg_o        (seg_o),
    .dp_o         (dp_o)
  );

endmodule

/* stopwatch_assertions.sv */
module stopwatch_assertions (
  input logic                  clk_i,
  input logic                  rstn_i,
  input logic                  run_i,
  input logic                  set_press_i,
  input logic                  edit_i,
  input logic                  load_i,
  input sw_pkg::setter_state_e state_i,
  input sw_pkg::bcd_t          hund_i,
  input sw_pkg::bcd_t          tenth_i,
  input sw_pkg::bcd_t          sec_i,
  input sw_pkg::bcd_t          ten_i,
  input sw_pkg::bcd_t          edit_hund_i,
  input sw_pkg::bcd_t          edit_tenth_i,
  input sw_pkg::bcd_t          edit_sec_i,
  input sw_pkg::bcd_t          edit_ten_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import sw_pkg::*;

  logic digits_ok;

  // Count digits come straight from the counter.
  assign digits_ok = (hund_i <= 4'd9) && (tenth_i <= 4'd9) && (sec_i <= 4'd9)
                  && (ten_i <= 4'd9) && (edit_hund_i <= 4'd9) && (edit_tenth_i <= 4'd9)
                  && (edit_sec_i <= 4'd9) && (edit_ten_i <= 4'd9);

  load_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    load_i |=> !load_i)
    else $error("load strobe stayed high for more than one cycle");

  load_stopped: assert property (@(posedge clk_i) disable iff (!rstn_i)
    load_i |-> !run_i)
    else $error("load strobe while the counter runs");

  digits_bcd: assert property (@(posedge clk_i) disable iff (!rstn_i) digits_ok)
    else $error("a digit left the range 0 to 9");

  // Edit opens at the tens digit, only on a set press while stopped.
  edit_entry: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $rose(edit_i) |-> $past(set_press_i && !run_i) && (state_i == CHANGE_TEN))
    else $error("edit mode entered without a set press while stopped");

  // Edit closes from the hundredths digit together with the load.
  edit_exit: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $fell(edit_i) |-> load_i && ($past(state_i) == CHANGE_HUND))
    else $error("edit mode left without a load strobe from the last digit");

endmodule

bind stopwatch_setter stopwatch_assertions u_stopwatch_assertions (
  .clk_i        (clk_i),
  .rstn_i       (rstn_i),
  .run_i        (run_i),
  .set_press_i  (set_press_i),
  .edit_i       (edit_o),
  .load_i       (load_o),
  .state_i      (state_q),
  .hund_i       (hund_i),
  .tenth_i      (tenth_i),
  .sec_i        (sec_i),
  .ten_i        (ten_i),
  .edit_hund_i  (hund_q),
  .edit_tenth_i (tenth_q),
  .edit_sec_i   (sec_q),
  .edit_ten_i   (ten_q)
);

/* tb_stopwatch.sv */
module tb_stopwatch;
  timeunit 1ns;
  timeprecision 1ps;
  import sw_pkg::*;

  localparam int CLK_PERIOD     = 4;
  localparam int CAPTURE_CYCLES = 4 * SCAN_CYCLES + 2;
  localparam int SETTLE_CYCLES  = 2 + DEBOUNCE_CYCLES + 4;
  localparam int PRESS_COST     = 2 * (DEBOUNCE_CYCLES + 7) + SETTLE_CYCLES + 1;

  logic       clk_i = 1'b0;
  logic       rstn_i;
  logic       btn_start_i;
  logic       btn_set_i;
  logic       btn_change_i;
  logic [3:0] anode_o;
  logic [6:0] seg_o;
  logic       dp_o;
  logic       run_o;
  logic       edit_o;

  int  seed = 32'hd0cc;
  int  errors;
  int  checks;
  int  passed;
  int  failed;
  int  budget;
  int  last_value;
  time start_prev;
  time start_last;

  stopwatch_top u_stopwatch_top (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .btn_start_i  (btn_start_i),
    .btn_set_i    (btn_set_i),
    .btn_change_i (btn_change_i),
    .anode_o      (anode_o),
    .seg_o        (seg_o),
    .dp_o         (dp_o),
    .run_o        (run_o),
    .edit_o       (edit_o)
  );

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Helpers.
  ////////////////////////////////////////////////////////////

  // Segments gfedcba back to a digit, -1 if unknown.
  function automatic int digit_of(input logic [6:0] seg);
    case (seg)
      7'b0111111: return 0;
      7'b0000110: return 1;
      7'b1011011: return 2;
      7'b1001111: return 3;
      7'b1100110: return 4;
      7'b1101101: return 5;
      7'b1111101: return 6;
      7'b0000111: return 7;
      7'b1111111: return 8;
      7'b1101111: return 9;
      default:    return -1;
    endcase
  endfunction

  function automatic int clamp(input int v, input int lo, input int hi);
    if (v < lo)
      return lo;
    if (v > hi)
      return hi;
    return v;
  endfunction

  // Cycles one command line may take, for the watchdog.
  function automatic int line_cost(input string line);
    string cmd;
    string arg;
    int    num;
    int    n;
    num = 0;
    n   = $sscanf(line, "%s", cmd);
    if (n < 1)
      return 0;
    if (cmd == "P")
    begin
      n = $sscanf(line, "%s %s %d", cmd, arg, num);
      return num * PRESS_COST;
    end
    if (cmd == "W" || cmd == "G")
    begin
      n = $sscanf(line, "%s %d", cmd, num);
      return num + SETTLE_CYCLES + 1;
    end
    if (cmd == "E" || cmd == "F" || cmd == "U" || cmd == "L")
      return CAPTURE_CYCLES + 1;
    if (cmd == "S" || cmd == "Z")
      return 10;
    return 0;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected !== actual)
    begin
      errors++;
      $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic set_button(input string name, input logic level);
    if (name == "start")
      btn_start_i <= level;
    else if (name == "set")
      btn_set_i <= level;
    else if (name == "change")
      btn_change_i <= level;
    else
    begin
      errors++;
      $display("Unknown button name '%s' in the command file", name);
    end
  endtask

  // Hold and release with a little random length, then let it settle.
  task automatic press_button(input string name, input int count);
    int hold;
    int i;
    for (i = 0; i < count; i++)
    begin
      hold = DEBOUNCE_CYCLES + 4 + int'($unsigned($random(seed)) % 4);
      @(posedge clk_i);
      if (name == "start")
      begin
        start_prev = start_last;
        start_last = $time;
      end
      set_button(name, 1'b1);
      repeat (hold) @(posedge clk_i);
      set_button(name, 1'b0);
      repeat (hold + SETTLE_CYCLES) @(posedge clk_i);
    end
  endtask

  task automatic glitch_start(input int cycles);
    @(posedge clk_i);
    btn_start_i <= 1'b1;
    repeat (cycles) @(posedge clk_i);
    btn_start_i <= 1'b0;
    repeat (SETTLE_CYCLES) @(posedge clk_i);
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rstn_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    rstn_i <= 1'b1;
  endtask

  // One full scan, decoded into ttss as a number.
  task automatic capture_display(output int value);
    int digs [4];
    int idx;
    int d;
    int i;
    for (i = 0; i < 4; i++)
      digs[i] = -1;
    repeat (CAPTURE_CYCLES)
    begin
      @(negedge clk_i);
      case (anode_o)
        4'b0001: idx = 0;
        4'b0010: idx = 1;
        4'b0100: idx = 2;
        4'b1000: idx = 3;
        default: idx = -1;
      endcase
      if (idx < 0)
      begin
        errors++;
        $display("Anode pattern %b at %0t is not one-hot", anode_o, $time);
      end
      else
      begin
        d = digit_of(seg_o);
        if (d < 0)
        begin
          errors++;
          $display("Segment pattern %b at %0t is not a decimal digit", seg_o, $time);
        end
        else
          digs[idx] = d;
        check_value("dp_o", int'(idx == 2), int'(dp_o));
      end
    end
    value = 0;
    for (i = 3; i >= 0; i--)
    begin
      if (digs[i] < 0)
      begin
        errors++;
        $display("Display digit %0d was never decoded during the scan", i);
      end
      value = value * 10 + ((digs[i] < 0) ? 0 : digs[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Command interpreter.
  ////////////////////////////////////////////////////////////

  task automatic run_command(input string line);
    string cmd;
    string arg;
    string desc;
    int    num;
    int    n;
    int    value;
    int    hi;
    int    err_before;
    bit    is_check;
    num        = 0;
    is_check   = 1'b0;
    err_before = errors;
    n = $sscanf(line, "%s", cmd);
    if (n < 1 || cmd.substr(0, 0) == "#")
      return;
    if (cmd == "P")
    begin
      n = $sscanf(line, "%s %s %d", cmd, arg, num);
      press_button(arg, num);
    end
    else if (cmd == "W" || cmd == "G")
    begin
      n = $sscanf(line, "%s %d", cmd, num);
      if (cmd == "W")
        repeat (num) @(posedge clk_i);
      else
        glitch_start(num);
    end
    else if (cmd == "Z")
      apply_reset();
    else if (cmd == "S")
    begin
      n = $sscanf(line, "%s %s %d", cmd, arg, num);
      @(negedge clk_i);
      if (arg == "run")
        check_value("run_o", num, int'(run_o));
      else
        check_value("edit_o", num, int'(edit_o));
      desc     = $sformatf("S %s %0d", arg, num);
      is_check = 1'b1;
    end
    else if (cmd == "E" || cmd == "F" || cmd == "U" || cmd == "L")
    begin
      n = $sscanf(line, "%s %d", cmd, num);
      capture_display(value);
      if (cmd == "E")
        check_value("display", num, value);
      else if (cmd == "F")
        check_value("display", last_value, value);
      else if (cmd == "U")
      begin
        // At most one hundredth per CLK_PER_HUNDREDTH cycles of run time.
        hi = num + int'((start_last - start_prev) / CLK_PERIOD) / CLK_PER_HUNDREDTH;
        check_value("display", clamp(value, num + 1, hi), value);
      end
      else
        check_value("display", clamp(value, 0, num - 1), value);
      last_value = value;
      desc       = $sformatf("%s %0d", cmd, num);
      is_check   = 1'b1;
    end
    else
    begin
      errors++;
      $display("Unknown command '%s' in the command file", cmd);
    end
    if (is_check)
    begin
      checks++;
      if (errors == err_before)
        passed++;
      else
        failed++;
      $display("check %0d (%s): %s", checks, desc, (errors == err_before) ? "ok" : "mismatch");
    end
  endtask

  initial
  begin
    string line;
    int    fd;
    int    total;
    rstn_i       = 1'b0;
    btn_start_i  = 1'b0;
    btn_set_i    = 1'b0;
    btn_change_i = 1'b0;
    errors       = 0;
    checks       = 0;
    passed       = 0;
    failed       = 0;
    budget       = 0;
    last_value   = 0;
    start_prev   = 0;
    start_last   = 0;
    total        = 0;
    fd = $fopen("stopwatch_input.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open stopwatch_input.txt for reading");
      $display("Test failed");
      $finish;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
        total += line_cost(line);
      $fclose(fd);
      budget = 2 * (total + 10) + 1000;
      apply_reset();
      fd = $fopen("stopwatch_input.txt", "r");
      while ($fgets(line, fd) != 0)
        run_command(line);
      $fclose(fd);
      $display("checks: %0d passed, %0d failed, %0d errors", passed, failed, errors);
      if (errors == 0)
        $display("Test completed successfully");
      else
        $display("Test failed");
      $finish;
    end
  end

  // Watchdog.
  initial
  begin
    wait (budget > 0);
    repeat (budget) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles before the commands finished", budget);
    $display("Test failed");
    $finish;
  end

endmodule

/* stopwatch_top.f */
sw_pkg.sv
button_conditioner.sv
time_counter.sv
stopwatch_setter.sv
seg_scan.sv
stopwatch_top.sv
stopwatch_assertions.sv
tb_stopwatch.sv

/* run_sim.sh */
#!/bin/sh
# Builds the stopwatch testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_stopwatch -f stopwatch_top.f --Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile step returned an error"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
  echo "No pass line found in $LOG"
  exit 1
fi
exit 0

/* stopwatch_input.txt */
# Columns: P <start|set|change> <presses>, W <cycles>, E <digits ttss>, F (display frozen)
# S <run|edit> <level>, U <base> (ran from base), L <limit> (below), G <cycles> glitch, Z reset
E 0000
S run 0
S edit 0
# Edit to 32.91, hundredths wrap past 9.
P set 1
S edit 1
P change 3
P set 1
P change 2
P set 1
P change 9
P set 1
P change 11
E 3291
P set 1
E 3291
S edit 0
# Run for 40 hundredths, then stop.
P start 1
W 640
P start 1
U 3291
W 200
F
# Presses that are not legal.
P start 1
P set 1
S edit 0
P start 1
P set 1
P start 1
S run 0
# Wrap from 99.95.
Z
P set 1
P change 9
P set 1
P change 9
P set 1
P change 9
P set 1
P change 5
P set 1
E 9995
P start 1
W 160
P start 1
L 100
# Short start pulse.
G 5
W 40
S run 0
